// File: sim.f
source/wr_conv_pkg.sv
source/wr_cmd_fsm.sv
source/wr_cmd_translator.sv
source/b_id_fifo.sv
source/b_resp_merge.sv
source/wr_conv_top.sv
verification/wr_conv_assert.sv
verification/wr_conv_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module wr_conv_tb -f sim.f -o sim_wr_conv
out=$(./obj_dir/sim_wr_conv) || true
echo "$out"
if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

// File: verification/wr_conv_tb.sv
module wr_conv_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [wr_conv_pkg::resp_w-1:0] resp_t;

  localparam int total_bursts = 38;
  localparam int cycle_limit  = 40 * total_bursts;

  logic                   clk = 1'b0;
  logic                   reset;
  wr_conv_pkg::aw_burst_t s_aw;
  logic                   s_awvalid;
  logic                   s_awready;
  wr_conv_pkg::aw_beat_t  m_aw;
  logic                   m_awvalid;
  logic                   m_awready = 1'b0;
  resp_t                  m_bresp = '0;
  logic                   m_bvalid = 1'b0;
  logic                   m_bready;
  wr_conv_pkg::b_resp_t   s_b;
  logic                   s_bvalid;
  logic                   s_bready = 1'b0;

  logic [31:0]            lfsr = 32'hd74f;
  logic                   stall_on = 1'b0;
  logic                   bready_hold = 1'b0;
  string                  test_name = "reset";
  wr_conv_pkg::aw_beat_t  exp_aw[$];
  wr_conv_pkg::b_resp_t   exp_b[$];
  resp_t                  bresp_q[$];  // One code per master beat, in command order.
  int                     aw_acc = 0;  // Every s_awready pulse.
  int                     aw_beats = 0;
  int                     b_done = 0;
  int                     mb_acc = 0;
  int                     mb_seen = 0;
  int                     b_sent = 0;
  int                     b_delay = 0;
  int                     checks = 0;
  int                     mon_errors = 0;
  int                     seq_errors = 0;
  int                     start_errors = 0;
  int                     sent = 0;
  int                     tests = 0;
  int                     cycles = 0;

  wr_conv_top dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // INCR beat addresses and the worst response code of one burst.
  function automatic void expect_burst(input wr_conv_pkg::aw_burst_t b, input resp_t codes[$],
                                       output wr_conv_pkg::aw_beat_t beats[$],
                                       output wr_conv_pkg::b_resp_t merged);
    wr_conv_pkg::aw_beat_t beat;
    beats       = {};
    merged.id   = b.id;
    merged.resp = wr_conv_pkg::resp_okay;
    for (int i = 0; i <= int'(b.len); i++) begin
      beat.addr = b.addr + 32'(i) * (32'd1 << b.size);
      beat.id   = b.id;
      beats.push_back(beat);
    end
    foreach (codes[i]) begin
      if (codes[i] > merged.resp) begin
        merged.resp = codes[i];
      end
    end
  endfunction

  task automatic send_burst(input wr_conv_pkg::aw_burst_t b, input resp_t codes[$]);
    wr_conv_pkg::aw_beat_t beats[$];
    wr_conv_pkg::b_resp_t  merged;
    expect_burst(b, codes, beats, merged);
    foreach (beats[i]) exp_aw.push_back(beats[i]);
    foreach (codes[i]) bresp_q.push_back(codes[i]);
    exp_b.push_back(merged);
    sent++;
    s_aw      = b;
    s_awvalid = 1'b1;
    @(negedge clk);
    while (aw_acc < sent) @(negedge clk);
    s_awvalid = 1'b0;  // Cleared before the idle FSM can see it again.
  endtask

  task automatic send_random_burst(input logic [7:0] len_mask);
    wr_conv_pkg::aw_burst_t b;
    resp_t                  codes[$];
    b.size = 3'(rand_bits(3));
    b.len  = 8'(rand_bits(8)) & len_mask;
    b.id   = 4'(rand_bits(4));
    b.addr = rand_bits(32) & ~((32'd1 << b.size) - 32'd1);
    for (int i = 0; i <= int'(b.len); i++) begin
      codes.push_back(resp_t'(rand_bits(2)));
    end
    send_burst(b, codes);
  endtask

  task automatic start_test(input string name, input logic stalls);
    test_name    = name;
    stall_on     = stalls;
    start_errors = mon_errors + seq_errors;
  endtask

  task automatic finish_test();
    while ((aw_beats != exp_aw.size()) || (b_done != exp_b.size())) @(negedge clk);
    assert (aw_acc == sent) else begin
      $display("ERROR %s: s_awready pulses expected %0d, actual %0d", test_name, sent, aw_acc);
      seq_errors++;
    end
    tests++;
    $display("Test %s done, %0d errors", test_name, mon_errors + seq_errors - start_errors);
  endtask

  // Master side model and slave B ready.
  always @(negedge clk) begin
    m_awready = stall_on ? 1'(rand_bits(1)) : 1'b1;
    s_bready  = bready_hold ? 1'b0 : (stall_on ? 1'(rand_bits(1)) : 1'b1);
    if (mb_acc != mb_seen) begin
      m_bvalid = 1'b0;
      mb_seen  = mb_acc;
    end
    if (!m_bvalid && (b_sent < aw_beats)) begin
      if (b_delay == 0) begin
        m_bresp  = bresp_q[b_sent];
        m_bvalid = 1'b1;
        b_sent++;
        b_delay  = int'(rand_bits(2));
      end else begin
        b_delay--;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (s_awready) aw_acc++;
      if (m_bvalid && m_bready) mb_acc++;
      if (m_awvalid && m_awready) begin
        checks++;
        assert (aw_beats < exp_aw.size()) else begin
          $display("Extra m_aw beat with no burst behind it in test %s", test_name);
          mon_errors++;
        end
        if (aw_beats < exp_aw.size()) begin
          assert (m_aw === exp_aw[aw_beats]) else begin
            $display("ERROR %s: m_aw expected %h, actual %h", test_name, exp_aw[aw_beats], m_aw);
            mon_errors++;
          end
        end
        aw_beats++;
      end
      if (s_bvalid && s_bready) begin
        checks++;
        assert (b_done < exp_b.size()) else begin
          $display("Extra s_b response in test %s", test_name);
          mon_errors++;
        end
        if (b_done < exp_b.size()) begin
          assert (s_b === exp_b[b_done]) else begin
            $display("ERROR %s: s_b expected %h, actual %h", test_name, exp_b[b_done], s_b);
            mon_errors++;
          end
        end
        b_done++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout, run still busy after %0d cycles in test %s", cycles, test_name);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    wr_conv_pkg::aw_burst_t burst;
    resp_t                  codes[$];
    int                     mark;
    reset     = 1'b1;
    s_aw      = '0;
    s_awvalid = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    start_test("single_beat", 1'b0);
    repeat (4) send_random_burst(8'h00);
    finish_test();

    start_test("multi_beat", 1'b0);
    repeat (6) send_random_burst(8'h07);
    finish_test();

    start_test("mixed_resp", 1'b0);
    burst.addr = 32'h0000_1000;
    burst.len  = 8'd3;
    burst.size = 3'd2;
    burst.id   = 4'h5;
    codes = '{wr_conv_pkg::resp_okay, wr_conv_pkg::resp_slverr,
              wr_conv_pkg::resp_okay, wr_conv_pkg::resp_exokay};
    send_burst(burst, codes);
    burst.len = 8'd1;
    burst.id  = 4'h9;
    codes = '{wr_conv_pkg::resp_decerr, wr_conv_pkg::resp_exokay};
    send_burst(burst, codes);
    finish_test();

    start_test("aw_stalls", 1'b1);
    repeat (8) send_random_burst(8'h07);
    finish_test();

    // More bursts than the FIFO can track while s_bready is held low.
    start_test("b_backpressure", 1'b0);
    bready_hold = 1'b1;
    mark        = aw_acc;
    fork
      repeat (6) send_random_burst(8'h00);
      begin
        repeat (30) @(negedge clk);
        assert (aw_acc - mark == wr_conv_pkg::fifo_depth) else begin
          $display("ERROR %s: bursts accepted with responses stalled expected %0d, actual %0d",
                   test_name, wr_conv_pkg::fifo_depth, aw_acc - mark);
          seq_errors++;
        end
        bready_hold = 1'b0;
      end
    join
    finish_test();

    start_test("back_to_back", 1'b1);
    repeat (12) send_random_burst(8'h07);
    finish_test();

    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, mon_errors + seq_errors, dut.u_assert.failures);
    if ((mon_errors + seq_errors + dut.u_assert.failures) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verification/wr_conv_assert.sv
module wr_conv_assert (
  input logic                  clk,
  input logic                  reset,
  input logic                  s_awvalid,
  input logic                  s_awready,
  input wr_conv_pkg::aw_beat_t m_aw,
  input logic                  m_awvalid,
  input logic                  m_awready,
  input wr_conv_pkg::b_resp_t  s_b,
  input logic                  s_bvalid,
  input logic                  s_bready
);

  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  // Master command is held until taken.
  assert property (@(posedge clk) disable iff (reset)
    (m_awvalid && !m_awready) |=> (m_awvalid && $stable(m_aw)))
    else begin
      $error("m_aw changed or m_awvalid dropped before m_awready");
      failures++;
    end

  assert property (@(posedge clk) disable iff (reset)
    (s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_b)))
    else begin
      $error("s_b changed or s_bvalid dropped before s_bready");
      failures++;
    end

  assert property (@(posedge clk) disable iff (reset) s_awready |-> s_awvalid)
    else begin
      $error("s_awready high while s_awvalid is low");
      failures++;
    end

endmodule

bind wr_conv_top wr_conv_assert u_assert (.*);

// File: source/wr_conv_top.sv
module wr_conv_top (
  input  logic                           clk,
  input  logic                           reset,
  input  wr_conv_pkg::aw_burst_t         s_aw,
  input  logic                           s_awvalid,
  output logic                           s_awready,
  output wr_conv_pkg::aw_beat_t          m_aw,
  output logic                           m_awvalid,
  input  logic                           m_awready,
  input  logic [wr_conv_pkg::resp_w-1:0] m_bresp,
  input  logic                           m_bvalid,
  output logic                           m_bready,
  output wr_conv_pkg::b_resp_t           s_b,
  output logic                           s_bvalid,
  input  logic                           s_bready
);

  logic                  a_push;
  logic                  next;
  logic                  next_pending;
  logic                  b_push;
  logic                  b_full;
  logic                  b_empty;
  logic                  b_pop;
  wr_conv_pkg::b_track_t track_in;
  wr_conv_pkg::b_track_t track_head;

  wr_cmd_fsm u_fsm (
    .clk          (clk),
    .reset        (reset),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .m_awvalid    (m_awvalid),
    .m_awready    (m_awready),
    .next         (next),
    .next_pending (next_pending),
    .b_push       (b_push),
    .b_full       (b_full),
    .a_push       (a_push)
  );

  wr_cmd_translator u_translator (
    .clk          (clk),
    .reset        (reset),
    .s_aw         (s_aw),
    .a_push       (a_push),
    .next         (next),
    .m_aw         (m_aw),
    .next_pending (next_pending),
    .track        (track_in)
  );

  b_id_fifo u_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (b_push),
    .din   (track_in),
    .full  (b_full),
    .pop   (b_pop),
    .empty (b_empty),
    .dout  (track_head)
  );

  b_resp_merge u_merge (
    .clk      (clk),
    .reset    (reset),
    .track    (track_head),
    .empty    (b_empty),
    .pop      (b_pop),
    .m_bvalid (m_bvalid),
    .m_bresp  (m_bresp),
    .m_bready (m_bready),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .s_b      (s_b)
  );

endmodule

// File: source/b_resp_merge.sv
module b_resp_merge (
  input  logic                               clk,
  input  logic                               reset,
  input  wr_conv_pkg::b_track_t              track,
  input  logic                               empty,
  output logic                               pop,
  input  logic                               m_bvalid,
  input  logic [wr_conv_pkg::resp_w-1:0]     m_bresp,
  output logic                               m_bready,
  output logic                               s_bvalid,
  input  logic                               s_bready,
  output wr_conv_pkg::b_resp_t               s_b
);

  logic [wr_conv_pkg::len_w-1:0]  beat_cnt;
  logic [wr_conv_pkg::resp_w-1:0] merged;
  logic [wr_conv_pkg::resp_w-1:0] merged_nxt;
  logic                           beat_take;

  assign m_bready  = !empty && !s_bvalid;
  assign beat_take = m_bvalid && m_bready;
  assign pop       = s_bvalid && s_bready;

  // Worst code wins.
  assign merged_nxt = (m_bresp > merged) ? m_bresp : merged;

  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
      merged   <= wr_conv_pkg::resp_okay;
      s_bvalid <= 1'b0;
    end else if (pop) begin
      beat_cnt <= '0;
      merged   <= wr_conv_pkg::resp_okay;
      s_bvalid <= 1'b0;
    end else if (beat_take) begin
      merged <= merged_nxt;
      if (beat_cnt == track.len) begin
        s_bvalid <= 1'b1; // Last beat of the head burst.
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    s_b.id   = track.id;
    s_b.resp = merged;
  end

endmodule

// File: source/b_id_fifo.sv
module b_id_fifo (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  wr_conv_pkg::b_track_t din,
  output logic                  full,
  input  logic                  pop,
  output logic                  empty,
  output wr_conv_pkg::b_track_t dout
);

  wr_conv_pkg::b_track_t            mem [wr_conv_pkg::fifo_depth];
  logic [wr_conv_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [wr_conv_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [wr_conv_pkg::fifo_ptr_w:0]   count;
  logic                               do_push;
  logic                               do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at the power-of-two depth.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign full  = (count == wr_conv_pkg::fifo_depth);
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr]; // Head shows without a read.

endmodule

// File: source/wr_cmd_translator.sv
module wr_cmd_translator (
  input  logic                   clk,
  input  logic                   reset,
  input  wr_conv_pkg::aw_burst_t s_aw,
  input  logic                   a_push,
  input  logic                   next,
  output wr_conv_pkg::aw_beat_t  m_aw,
  output logic                   next_pending,
  output wr_conv_pkg::b_track_t  track
);

  wr_conv_pkg::aw_burst_t           burst;      // Addr field walks through the beats.
  logic [wr_conv_pkg::len_w-1:0]  remaining;  // Beats left after the current one.
  logic [wr_conv_pkg::addr_w-1:0] beat_bytes;

  assign beat_bytes = {{(wr_conv_pkg::addr_w-1){1'b0}}, 1'b1} << burst.size;

  always_ff @(posedge clk) begin
    if (a_push) begin
      burst <= s_aw;
    end else if (next) begin
      burst.addr <= burst.addr + beat_bytes; // INCR step.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
    end else if (a_push) begin
      remaining <= s_aw.len;
    end else if (next && (remaining != '0)) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign next_pending = (remaining != '0);

  always_comb begin
    m_aw.addr = burst.addr;
    m_aw.id   = burst.id;
  end

  // Original length is kept for the response counter.
  always_comb begin
    track.id  = burst.id;
    track.len = burst.len;
  end

endmodule

// File: source/wr_cmd_fsm.sv
module wr_cmd_fsm (
  input  logic clk,
  input  logic reset,
  input  logic s_awvalid,
  output logic s_awready,
  output logic m_awvalid,
  input  logic m_awready,
  output logic next,
  input  logic next_pending,
  output logic b_push,
  input  logic b_full,
  output logic a_push
);

  logic [1:0] state;
  logic [1:0] next_state;
  logic       burst_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wr_conv_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      wr_conv_pkg::st_idle: begin
        if (s_awvalid) begin
          next_state = wr_conv_pkg::st_cmd_en;
        end
      end
      wr_conv_pkg::st_cmd_en: begin
        if (m_awready) begin
          if (next_pending) begin
            next_state = wr_conv_pkg::st_accepted;
          end else if (b_full) begin
            next_state = wr_conv_pkg::st_done_wait; // No room to track the response.
          end else begin
            next_state = wr_conv_pkg::st_idle;
          end
        end
      end
      wr_conv_pkg::st_accepted: begin
        next_state = wr_conv_pkg::st_cmd_en;
      end
      wr_conv_pkg::st_done_wait: begin
        if (!b_full) begin
          next_state = wr_conv_pkg::st_idle;
        end
      end
      default: begin
        next_state = wr_conv_pkg::st_idle;
      end
    endcase
  end

  // Last beat taken and the tracker has room.
  assign burst_done = ((state == wr_conv_pkg::st_cmd_en) ||
                       (state == wr_conv_pkg::st_done_wait)) &&
                      (next_state == wr_conv_pkg::st_idle);

  assign m_awvalid = (state == wr_conv_pkg::st_cmd_en);
  assign a_push    = (state == wr_conv_pkg::st_idle);   // Translator follows s_aw while idle.
  assign next      = (state == wr_conv_pkg::st_accepted) || burst_done;
  assign s_awready = burst_done;
  assign b_push    = burst_done;

endmodule

// File: source/wr_conv_pkg.sv
package wr_conv_pkg;

  localparam int addr_w     = 32;
  localparam int id_w       = 4;
  localparam int len_w      = 8;  // Beats minus one.
  localparam int size_w     = 3;  // Log2 of bytes per beat.
  localparam int resp_w     = 2;
  localparam int fifo_depth = 4;  // Outstanding bursts.
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  localparam logic [resp_w-1:0] resp_okay   = 2'd0;
  localparam logic [resp_w-1:0] resp_exokay = 2'd1;
  localparam logic [resp_w-1:0] resp_slverr = 2'd2;
  localparam logic [resp_w-1:0] resp_decerr = 2'd3;

  // Command FSM state encodings.
  localparam logic [1:0] st_idle      = 2'b00;
  localparam logic [1:0] st_cmd_en    = 2'b01;
  localparam logic [1:0] st_accepted  = 2'b10;
  localparam logic [1:0] st_done_wait = 2'b11;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;
    logic [size_w-1:0] size;
    logic [id_w-1:0]   id;
  } aw_burst_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [id_w-1:0]   id;
  } aw_beat_t;

  typedef struct packed {
    logic [id_w-1:0]  id;
    logic [len_w-1:0] len;
  } b_track_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [resp_w-1:0] resp;
  } b_resp_t;

endpackage
